// File: ns_msg_pkg.sv
package ns_msg_pkg;

	// Message field widths
	localparam int ASZ_DEF = 6;
	localparam int DSZ_DEF = 32;
	localparam int RSZ_DEF = 4;

	// Destination range that the generators cycle through
	localparam int MIN_ADDR_DEF = 1;
	localparam int MAX_ADDR_DEF = 3;

	// Generator source addresses
	localparam int SRC0_ID = 0;
	localparam int SRC1_ID = 1;

	// Last nibble value before a source's count wraps.
	// The checker skips the order check right after this value.
	localparam int CNT_WRAP = 15;

endpackage

// File: ns_chnl_pkg.sv
package ns_chnl_pkg;

	// Debounce lengths in snk0_clk cycles
	localparam int REQ_CKS_DEF = 2;
	localparam int ACK_CKS_DEF = 2;

	// Bit positions in dbg_leds
	localparam int LED_SRC0 = 0;
	localparam int LED_SRC1 = 1;
	localparam int LED_BAD_SRC = 2;
	localparam int LED_REDUN = 3;

endpackage

// File: calc_redun.sv
`timescale 1ns/100ps

module calc_redun
	import ns_msg_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF
) (
	input  logic [ASZ-1:0] src,
	input  logic [ASZ-1:0] dst,
	input  logic [DSZ-1:0] dat,
	output logic [RSZ-1:0] redun
);

	// Wide enough that the three-way sum never overflows
	localparam int SW = ((ASZ > DSZ) ? ASZ : DSZ) + 2;

	logic [SW-1:0] sum;

	assign sum = SW'(src) + SW'(dst) + SW'(dat);
	assign redun = sum[RSZ-1:0];

endmodule

// File: chnl_debouncer.sv
`timescale 1ns/100ps

module chnl_debouncer
	import ns_chnl_pkg::*;
#(
	parameter int CKS = REQ_CKS_DEF
) (
	input  logic snk0_clk,
	input  logic rst_n,
	input  logic lvl,
	output logic ckd
);

	localparam int CW = $clog2(CKS + 1);

	logic [CW-1:0] cnt;

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			ckd <= 1'b0;
		end else if (lvl == ckd) begin
			cnt <= '0;
		end else if (cnt == CW'(CKS - 1)) begin
			// Level held long enough, take it
			cnt <= '0;
			ckd <= lvl;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: msg_source.sv
`timescale 1ns/100ps

module msg_source
	import ns_msg_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF,
	parameter int MIN_ADDR = MIN_ADDR_DEF,
	parameter int MAX_ADDR = MAX_ADDR_DEF,
	parameter int SRC_ID = SRC0_ID
) (
	input  logic snk0_clk,
	input  logic rst_n,
	input  logic ack_ckd,
	output logic [ASZ-1:0] src,
	output logic [ASZ-1:0] dst,
	output logic [DSZ-1:0] dat,
	output logic [RSZ-1:0] red,
	output logic req
);

	logic has_dst;
	logic has_dat;
	logic has_red;
	logic [3:0] cnt;
	logic [3:0] dat_nib;
	logic [ASZ-1:0] dst_nxt;
	logic [RSZ-1:0] redun;
	logic idle;
	logic load_dat;
	logic load_red;

	calc_redun #(
		.ASZ(ASZ),
		.DSZ(DSZ),
		.RSZ(RSZ)
	) u_calc_redun (
		.src(src),
		.dst(dst),
		.dat(dat),
		.redun(redun)
	);

	assign idle = !req && !ack_ckd;
	assign load_dat = idle && has_dst && !has_dat;
	assign load_red = idle && has_dst && has_dat && !has_red;
	assign dst_nxt = (dst >= ASZ'(MAX_ADDR)) ? ASZ'(MIN_ADDR) : dst + 1'b1;

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			has_dst <= 1'b0;
			has_dat <= 1'b0;
			has_red <= 1'b0;
			req <= 1'b0;
			dst <= ASZ'(MIN_ADDR);
			cnt <= '0;
		end else if (idle) begin
			// Build the message one field per cycle
			if (!has_dst) begin
				has_dst <= 1'b1;
				dst <= dst_nxt;
			end else if (!has_dat) begin
				has_dat <= 1'b1;
				cnt <= (cnt == 4'(CNT_WRAP)) ? '0 : cnt + 1'b1;
			end else if (!has_red) begin
				has_red <= 1'b1;
			end
			if (has_red)
				req <= 1'b1;
		end else if (req && ack_ckd) begin
			has_dst <= 1'b0;
			has_dat <= 1'b0;
			has_red <= 1'b0;
			req <= 1'b0;
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (load_dat)
			dat_nib <= cnt;
		if (load_red)
			red <= redun;
	end

	assign src = ASZ'(SRC_ID);
	assign dat = {{(DSZ - 4){1'b0}}, dat_nib};

endmodule

// File: msg_checker.sv
`timescale 1ns/100ps

module msg_checker
	import ns_msg_pkg::*;
	import ns_chnl_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF
) (
	input  logic snk0_clk,
	input  logic rst_n,
	input  logic req_ckd,
	input  logic [ASZ-1:0] src,
	input  logic [ASZ-1:0] dst,
	input  logic [DSZ-1:0] dat,
	input  logic [RSZ-1:0] red,
	output logic ack,
	output logic [3:0] leds,
	output logic [3:0] disp0
);

	localparam logic [ASZ-1:0] SRC_IDS [2] = '{ASZ'(SRC0_ID), ASZ'(SRC1_ID)};

	logic has_inp;
	logic has_redun;
	logic [ASZ-1:0] in_src;
	logic [ASZ-1:0] in_dst;
	logic [DSZ-1:0] in_dat;
	logic [RSZ-1:0] in_red;
	logic [RSZ-1:0] redun_c;
	logic [RSZ-1:0] redun_r;
	logic [DSZ-1:0] last_dat [2];
	logic [1:0] err_src;
	logic err_bad;
	logic err_redun;
	logic active;

	calc_redun #(
		.ASZ(ASZ),
		.DSZ(DSZ),
		.RSZ(RSZ)
	) u_calc_redun (
		.src(in_src),
		.dst(in_dst),
		.dat(in_dat),
		.redun(redun_c)
	);

	assign active = req_ckd && !ack;

	// Latched copy of the incoming message
	always_ff @(posedge snk0_clk) begin
		if (active && !has_inp) begin
			in_src <= src;
			in_dst <= dst;
			in_dat <= dat;
			in_red <= red;
		end
		if (active && has_inp && !has_redun)
			redun_r <= redun_c;
	end

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			has_inp <= 1'b0;
			has_redun <= 1'b0;
			ack <= 1'b0;
			disp0 <= '0;
			err_src <= '0;
			err_bad <= 1'b0;
			err_redun <= 1'b0;
			last_dat[0] <= DSZ'(CNT_WRAP);
			last_dat[1] <= DSZ'(CNT_WRAP);
		end else if (active) begin
			if (!has_inp) begin
				has_inp <= 1'b1;
			end else if (!has_redun) begin
				has_redun <= 1'b1;
			end else begin
				for (int s = 0; s < 2; s++) begin
					// A lit source LED stops further checks on it
					if (in_src == SRC_IDS[s] && !err_src[s]) begin
						if (in_red != redun_r) begin
							err_src[s] <= 1'b1;
							err_redun <= 1'b1;
						end else if (last_dat[s] < DSZ'(CNT_WRAP) &&
								in_dat != last_dat[s] + 1'b1) begin
							err_src[s] <= 1'b1;
						end else begin
							last_dat[s] <= in_dat;
						end
					end
				end
				if (in_src != SRC_IDS[0] && in_src != SRC_IDS[1])
					err_bad <= 1'b1;
				disp0 <= in_dat[3:0];
				has_inp <= 1'b0;
				has_redun <= 1'b0;
				ack <= 1'b1;
			end
		end else if (!req_ckd && ack) begin
			ack <= 1'b0;
		end
	end

	always_comb begin
		leds = '0;
		leds[LED_SRC0] = err_src[0];
		leds[LED_SRC1] = err_src[1];
		leds[LED_BAD_SRC] = err_bad;
		leds[LED_REDUN] = err_redun;
	end

endmodule

// File: io_2to1.sv
`timescale 1ns/100ps

module io_2to1
	import ns_msg_pkg::*;
	import ns_chnl_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF,
	parameter int MIN_ADDR = MIN_ADDR_DEF,
	parameter int MAX_ADDR = MAX_ADDR_DEF,
	parameter int REQ_CKS = REQ_CKS_DEF,
	parameter int ACK_CKS = ACK_CKS_DEF
) (
	input  logic snk0_clk,
	input  logic rst_n,
	output logic [ASZ-1:0] o0_src,
	output logic [ASZ-1:0] o0_dst,
	output logic [DSZ-1:0] o0_dat,
	output logic [RSZ-1:0] o0_red,
	output logic o0_req,
	input  logic o0_ack,
	output logic [ASZ-1:0] o1_src,
	output logic [ASZ-1:0] o1_dst,
	output logic [DSZ-1:0] o1_dat,
	output logic [RSZ-1:0] o1_red,
	output logic o1_req,
	input  logic o1_ack,
	input  logic [ASZ-1:0] i0_src,
	input  logic [ASZ-1:0] i0_dst,
	input  logic [DSZ-1:0] i0_dat,
	input  logic [RSZ-1:0] i0_red,
	input  logic i0_req,
	output logic i0_ack,
	output logic [3:0] dbg_leds,
	output logic [3:0] dbg_disp0
);

	logic o0_ack_ckd;
	logic o1_ack_ckd;
	logic i0_req_ckd;

	chnl_debouncer #(.CKS(ACK_CKS)) u_deb_o0_ack (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .lvl(o0_ack), .ckd(o0_ack_ckd)
	);
	chnl_debouncer #(.CKS(ACK_CKS)) u_deb_o1_ack (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .lvl(o1_ack), .ckd(o1_ack_ckd)
	);
	chnl_debouncer #(.CKS(REQ_CKS)) u_deb_i0_req (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .lvl(i0_req), .ckd(i0_req_ckd)
	);

	msg_source #(
		.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ),
		.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR), .SRC_ID(SRC0_ID)
	) u_src0 (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .ack_ckd(o0_ack_ckd),
		.src(o0_src), .dst(o0_dst), .dat(o0_dat), .red(o0_red), .req(o0_req)
	);

	msg_source #(
		.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ),
		.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR), .SRC_ID(SRC1_ID)
	) u_src1 (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .ack_ckd(o1_ack_ckd),
		.src(o1_src), .dst(o1_dst), .dat(o1_dat), .red(o1_red), .req(o1_req)
	);

	msg_checker #(.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ)) u_chk0 (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .req_ckd(i0_req_ckd),
		.src(i0_src), .dst(i0_dst), .dat(i0_dat), .red(i0_red),
		.ack(i0_ack), .leds(dbg_leds), .disp0(dbg_disp0)
	);

endmodule

// File: msg_merge_2to1.sv
`timescale 1ns/100ps

module msg_merge_2to1
	import ns_msg_pkg::*;
	import ns_chnl_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF,
	parameter int REQ_CKS = REQ_CKS_DEF,
	parameter int ACK_CKS = ACK_CKS_DEF
) (
	input  logic snk0_clk,
	input  logic rst_n,
	input  logic [ASZ-1:0] a_src,
	input  logic [ASZ-1:0] a_dst,
	input  logic [DSZ-1:0] a_dat,
	input  logic [RSZ-1:0] a_red,
	input  logic a_req,
	output logic a_ack,
	input  logic [ASZ-1:0] b_src,
	input  logic [ASZ-1:0] b_dst,
	input  logic [DSZ-1:0] b_dat,
	input  logic [RSZ-1:0] b_red,
	input  logic b_req,
	output logic b_ack,
	output logic [ASZ-1:0] out_src,
	output logic [ASZ-1:0] out_dst,
	output logic [DSZ-1:0] out_dat,
	output logic [RSZ-1:0] out_red,
	output logic out_req,
	input  logic out_ack
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SEND,
		ST_DONE,
		ST_ACK
	} state_t;

	state_t state;
	logic a_req_ckd;
	logic b_req_ckd;
	logic out_ack_ckd;
	logic prio_b;
	logic sel_b;
	logic pick_b;
	logic grant;
	logic sel_req_ckd;

	chnl_debouncer #(.CKS(REQ_CKS)) u_deb_a_req (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .lvl(a_req), .ckd(a_req_ckd)
	);
	chnl_debouncer #(.CKS(REQ_CKS)) u_deb_b_req (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .lvl(b_req), .ckd(b_req_ckd)
	);
	chnl_debouncer #(.CKS(ACK_CKS)) u_deb_out_ack (
		.snk0_clk(snk0_clk), .rst_n(rst_n), .lvl(out_ack), .ckd(out_ack_ckd)
	);

	// b wins when it is alone or holds the priority
	assign pick_b = b_req_ckd && (!a_req_ckd || prio_b);
	assign grant = (state == ST_IDLE) && (a_req_ckd || b_req_ckd);
	assign sel_req_ckd = sel_b ? b_req_ckd : a_req_ckd;

	always_ff @(posedge snk0_clk) begin
		if (grant) begin
			out_src <= pick_b ? b_src : a_src;
			out_dst <= pick_b ? b_dst : a_dst;
			out_dat <= pick_b ? b_dat : a_dat;
			out_red <= pick_b ? b_red : a_red;
		end
	end

	always_ff @(posedge snk0_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			prio_b <= 1'b0;
			sel_b <= 1'b0;
			out_req <= 1'b0;
			a_ack <= 1'b0;
			b_ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (grant) begin
						sel_b <= pick_b;
						prio_b <= !pick_b;
						state <= ST_LOAD;
					end
				end
				// Message registered last cycle, now stable
				ST_LOAD: begin
					out_req <= 1'b1;
					state <= ST_SEND;
				end
				ST_SEND: begin
					if (out_ack_ckd) begin
						out_req <= 1'b0;
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (!out_ack_ckd) begin
						a_ack <= !sel_b;
						b_ack <= sel_b;
						state <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!sel_req_ckd) begin
						a_ack <= 1'b0;
						b_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: ns_loop_top.sv
`timescale 1ns/100ps

module ns_loop_top
	import ns_msg_pkg::*;
	import ns_chnl_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF,
	parameter int MIN_ADDR = MIN_ADDR_DEF,
	parameter int MAX_ADDR = MAX_ADDR_DEF,
	parameter int REQ_CKS = REQ_CKS_DEF,
	parameter int ACK_CKS = ACK_CKS_DEF
) (
	input  logic snk0_clk,
	input  logic rst_n,
	output logic [ASZ-1:0] x0_src,
	output logic [ASZ-1:0] x0_dst,
	output logic [DSZ-1:0] x0_dat,
	output logic [RSZ-1:0] x0_red,
	output logic x0_req,
	input  logic x0_ack,
	input  logic [ASZ-1:0] i0_src,
	input  logic [ASZ-1:0] i0_dst,
	input  logic [DSZ-1:0] i0_dat,
	input  logic [RSZ-1:0] i0_red,
	input  logic i0_req,
	output logic i0_ack,
	output logic [3:0] dbg_leds,
	output logic [3:0] dbg_disp0
);

	// Generator channels into the merge
	logic [ASZ-1:0] o0_src;
	logic [ASZ-1:0] o0_dst;
	logic [DSZ-1:0] o0_dat;
	logic [RSZ-1:0] o0_red;
	logic o0_req;
	logic o0_ack;
	logic [ASZ-1:0] o1_src;
	logic [ASZ-1:0] o1_dst;
	logic [DSZ-1:0] o1_dat;
	logic [RSZ-1:0] o1_red;
	logic o1_req;
	logic o1_ack;

	io_2to1 #(
		.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ),
		.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR),
		.REQ_CKS(REQ_CKS), .ACK_CKS(ACK_CKS)
	) u_io_2to1 (
		.snk0_clk(snk0_clk), .rst_n(rst_n),
		.o0_src(o0_src), .o0_dst(o0_dst), .o0_dat(o0_dat), .o0_red(o0_red),
		.o0_req(o0_req), .o0_ack(o0_ack),
		.o1_src(o1_src), .o1_dst(o1_dst), .o1_dat(o1_dat), .o1_red(o1_red),
		.o1_req(o1_req), .o1_ack(o1_ack),
		.i0_src(i0_src), .i0_dst(i0_dst), .i0_dat(i0_dat), .i0_red(i0_red),
		.i0_req(i0_req), .i0_ack(i0_ack),
		.dbg_leds(dbg_leds), .dbg_disp0(dbg_disp0)
	);

	msg_merge_2to1 #(
		.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ),
		.REQ_CKS(REQ_CKS), .ACK_CKS(ACK_CKS)
	) u_merge (
		.snk0_clk(snk0_clk), .rst_n(rst_n),
		.a_src(o0_src), .a_dst(o0_dst), .a_dat(o0_dat), .a_red(o0_red),
		.a_req(o0_req), .a_ack(o0_ack),
		.b_src(o1_src), .b_dst(o1_dst), .b_dat(o1_dat), .b_red(o1_red),
		.b_req(o1_req), .b_ack(o1_ack),
		.out_src(x0_src), .out_dst(x0_dst), .out_dat(x0_dat), .out_red(x0_red),
		.out_req(x0_req), .out_ack(x0_ack)
	);

endmodule

// File: io_2to1_sva.sv
`timescale 1ns/100ps

module io_2to1_sva
	import ns_msg_pkg::*;
#(
	parameter int ASZ = ASZ_DEF,
	parameter int DSZ = DSZ_DEF,
	parameter int RSZ = RSZ_DEF
) (
	input logic snk0_clk,
	input logic rst_n,
	input logic [ASZ-1:0] src,
	input logic [ASZ-1:0] dst,
	input logic [DSZ-1:0] dat,
	input logic [RSZ-1:0] red,
	input logic req,
	input logic ack
);

	// Message frozen for the whole handshake
	a_msg_stable: assert property (
		@(posedge snk0_clk) disable iff (!rst_n)
		(req || ack) |-> $stable({src, dst, dat, red})
	) else $error("message changed while req or ack was high");

	a_req_holds: assert property (
		@(posedge snk0_clk) disable iff (!rst_n)
		$fell(req) |-> $past(ack)
	) else $error("req dropped before ack was raised");

	a_ack_holds: assert property (
		@(posedge snk0_clk) disable iff (!rst_n)
		$fell(ack) |-> !$past(req)
	) else $error("ack dropped while req was still high");

endmodule

bind msg_merge_2to1 io_2to1_sva #(.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ)) u_x0_sva (
	.snk0_clk(snk0_clk), .rst_n(rst_n),
	.src(out_src), .dst(out_dst), .dat(out_dat), .red(out_red),
	.req(out_req), .ack(out_ack)
);

bind io_2to1 io_2to1_sva #(.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ)) u_i0_sva (
	.snk0_clk(snk0_clk), .rst_n(rst_n),
	.src(i0_src), .dst(i0_dst), .dat(i0_dat), .red(i0_red),
	.req(i0_req), .ack(i0_ack)
);

// File: tb_ns_loop_top.sv
`timescale 1ns/100ps

module tb_ns_loop_top
	import ns_msg_pkg::*;
	import ns_chnl_pkg::*;
();

	localparam int ASZ = ASZ_DEF;
	localparam int DSZ = DSZ_DEF;
	localparam int RSZ = RSZ_DEF;
	localparam int NUM_X0 = 40;
	localparam int NUM_I0 = 14;
	// Longest random delays plus debounce and FSM overhead
	localparam int HS_LEN = 2 * 15 + 8 * (REQ_CKS_DEF + ACK_CKS_DEF) + 16;
	localparam int MAX_CYCLES = (NUM_X0 + NUM_I0) * HS_LEN * 2;

	logic snk0_clk;
	logic rst_n;
	logic [ASZ-1:0] x0_src;
	logic [ASZ-1:0] x0_dst;
	logic [DSZ-1:0] x0_dat;
	logic [RSZ-1:0] x0_red;
	logic x0_req;
	logic x0_ack;
	logic [ASZ-1:0] i0_src;
	logic [ASZ-1:0] i0_dst;
	logic [DSZ-1:0] i0_dat;
	logic [RSZ-1:0] i0_red;
	logic i0_req;
	logic i0_ack;
	logic [3:0] dbg_leds;
	logic [3:0] dbg_disp0;

	logic [15:0] lfsr;
	int cycles;
	// Expected generator state per source
	logic [ASZ-1:0] gen_dst [2];
	logic [3:0] gen_nib [2];
	logic [1:0] seen;
	// Expected checker state
	logic [DSZ-1:0] chk_last [2];
	logic [3:0] chk_leds;
	logic [3:0] chk_disp;

	ns_loop_top #(
		.ASZ(ASZ), .DSZ(DSZ), .RSZ(RSZ),
		.MIN_ADDR(MIN_ADDR_DEF), .MAX_ADDR(MAX_ADDR_DEF),
		.REQ_CKS(REQ_CKS_DEF), .ACK_CKS(ACK_CKS_DEF)
	) u_ns_loop_top (
		.snk0_clk(snk0_clk), .rst_n(rst_n),
		.x0_src(x0_src), .x0_dst(x0_dst), .x0_dat(x0_dat), .x0_red(x0_red),
		.x0_req(x0_req), .x0_ack(x0_ack),
		.i0_src(i0_src), .i0_dst(i0_dst), .i0_dat(i0_dat), .i0_red(i0_red),
		.i0_req(i0_req), .i0_ack(i0_ack),
		.dbg_leds(dbg_leds), .dbg_disp0(dbg_disp0)
	);

	always #4 snk0_clk = ~snk0_clk;

	always @(posedge snk0_clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: handshakes did not finish within %0d cycles", MAX_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	end

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Only the low bits of the sum survive, so add them modulo 2^RSZ
	function automatic logic [RSZ-1:0] redun_of(input logic [ASZ-1:0] src,
			input logic [ASZ-1:0] dst, input logic [DSZ-1:0] dat);
		return RSZ'(src) + RSZ'(dst) + RSZ'(dat);
	endfunction

	// Destinations cycle through MIN_ADDR_DEF..MAX_ADDR_DEF
	function automatic logic [ASZ-1:0] next_dst(input logic [ASZ-1:0] d);
		int span;
		span = MAX_ADDR_DEF - MIN_ADDR_DEF + 1;
		return ASZ'(MIN_ADDR_DEF + (int'(d) - MIN_ADDR_DEF + 1) % span);
	endfunction

	function automatic logic [DSZ-1:0] good_data(input int s);
		return (chk_last[s] >= DSZ'(CNT_WRAP)) ? '0 : chk_last[s] + DSZ'(1);
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge snk0_clk);
	endtask

	task automatic report_mismatch(input string sig, input logic [DSZ-1:0] got,
			input logic [DSZ-1:0] exp);
		$display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_msg(input logic [ASZ-1:0] src, input logic [ASZ-1:0] dst,
			input logic [DSZ-1:0] dat, input logic [RSZ-1:0] red);
		int s;
		logic [ASZ-1:0] exp_dst;
		logic [DSZ-1:0] exp_dat;
		logic [RSZ-1:0] exp_red;
		if (src !== ASZ'(SRC0_ID) && src !== ASZ'(SRC1_ID)) begin
			$display("Fail at %0d ns: x0_src is %0d, expected 0 or 1", $time, src);
			$display("RESULT: FAIL");
			$fatal(1);
		end
		s = (src == ASZ'(SRC1_ID)) ? 1 : 0;
		exp_dst = next_dst(gen_dst[s]);
		exp_dat = DSZ'(gen_nib[s]);
		exp_red = redun_of(src, exp_dst, exp_dat);
		if (dst !== exp_dst)
			report_mismatch("x0_dst", DSZ'(dst), DSZ'(exp_dst));
		if (dat !== exp_dat)
			report_mismatch("x0_dat", dat, exp_dat);
		if (red !== exp_red)
			report_mismatch("x0_red", DSZ'(red), DSZ'(exp_red));
		gen_dst[s] = exp_dst;
		gen_nib[s] = gen_nib[s] + 4'd1;
		seen[s] = 1'b1;
	endtask

	task automatic check_dbg(input logic [3:0] leds, input logic [3:0] disp0);
		if (leds !== chk_leds)
			report_mismatch("dbg_leds", DSZ'(leds), DSZ'(chk_leds));
		if (disp0 !== chk_disp)
			report_mismatch("dbg_disp0", DSZ'(disp0), DSZ'(chk_disp));
	endtask

	// x0 consumer with random back-pressure
	task automatic drain_x0(input int count);
		int n;
		for (n = 0; n < count; n++) begin
			while (!x0_req)
				@(posedge snk0_clk);
			check_msg(x0_src, x0_dst, x0_dat, x0_red);
			if (n == 3 && seen != 2'b11) begin
				$display("Only one source showed up in the first four x0 messages");
				$display("RESULT: FAIL");
				$fatal(1);
			end
			wait_cycles(int'(random_bits(4)));
			x0_ack <= 1'b1;
			while (x0_req)
				@(posedge snk0_clk);
			wait_cycles(int'(random_bits(2)));
			x0_ack <= 1'b0;
			@(posedge snk0_clk);
		end
	endtask

	// Expected effect of one i0 message on the LEDs and display
	task automatic model_i0(input logic [ASZ-1:0] src, input logic [DSZ-1:0] dat,
			input logic [RSZ-1:0] red, input logic [RSZ-1:0] good_red);
		int s;
		int led;
		if (src == ASZ'(SRC0_ID) || src == ASZ'(SRC1_ID)) begin
			s = (src == ASZ'(SRC1_ID)) ? 1 : 0;
			led = (s == 1) ? LED_SRC1 : LED_SRC0;
			if (!chk_leds[led]) begin
				if (red != good_red) begin
					chk_leds[led] = 1'b1;
					chk_leds[LED_REDUN] = 1'b1;
				end else if (chk_last[s] < DSZ'(CNT_WRAP) &&
						dat != chk_last[s] + DSZ'(1)) begin
					chk_leds[led] = 1'b1;
				end else begin
					chk_last[s] = dat;
				end
			end
		end else begin
			chk_leds[LED_BAD_SRC] = 1'b1;
		end
		chk_disp = dat[3:0];
	endtask

	task automatic send_i0(input logic [ASZ-1:0] src, input logic [ASZ-1:0] dst,
			input logic [DSZ-1:0] dat, input logic [RSZ-1:0] red);
		i0_src <= src;
		i0_dst <= dst;
		i0_dat <= dat;
		i0_red <= red;
		wait_cycles(1 + int'(random_bits(3)));
		i0_req <= 1'b1;
		model_i0(src, dat, red, redun_of(src, dst, dat));
		while (!i0_ack)
			@(posedge snk0_clk);
		check_dbg(dbg_leds, dbg_disp0);
		i0_req <= 1'b0;
		while (i0_ack)
			@(posedge snk0_clk);
	endtask

	task automatic send_good(input int s);
		logic [ASZ-1:0] src;
		logic [ASZ-1:0] dst;
		logic [DSZ-1:0] dat;
		src = (s == 1) ? ASZ'(SRC1_ID) : ASZ'(SRC0_ID);
		dst = ASZ'(random_bits(ASZ));
		dat = good_data(s);
		send_i0(src, dst, dat, redun_of(src, dst, dat));
	endtask

	initial begin
		logic [ASZ-1:0] dst;
		logic [DSZ-1:0] dat;
		snk0_clk = 1'b0;
		rst_n = 1'b0;
		x0_ack = 1'b0;
		i0_src = '0;
		i0_dst = '0;
		i0_dat = '0;
		i0_red = '0;
		i0_req = 1'b0;
		lfsr = 16'd60239;
		cycles = 0;
		gen_dst[0] = ASZ'(MIN_ADDR_DEF);
		gen_dst[1] = ASZ'(MIN_ADDR_DEF);
		gen_nib[0] = '0;
		gen_nib[1] = '0;
		seen = '0;
		chk_last[0] = DSZ'(CNT_WRAP);
		chk_last[1] = DSZ'(CNT_WRAP);
		chk_leds = '0;
		chk_disp = '0;
		repeat (3) @(posedge snk0_clk);
		rst_n <= 1'b1;

		drain_x0(NUM_X0);
		check_dbg(dbg_leds, dbg_disp0);

		repeat (8)
			send_good(int'(random_bits(1)));
		send_good(1);
		// Skip one count on source 1
		dst = ASZ'(random_bits(ASZ));
		dat = chk_last[1] + DSZ'(2);
		send_i0(ASZ'(SRC1_ID), dst, dat, redun_of(ASZ'(SRC1_ID), dst, dat));
		// Unknown source address
		dst = ASZ'(random_bits(ASZ));
		dat = random_bits(DSZ);
		send_i0(ASZ'(5), dst, dat, redun_of(ASZ'(5), dst, dat));
		// Corrupted red on source 0
		dst = ASZ'(random_bits(ASZ));
		dat = good_data(0);
		send_i0(ASZ'(SRC0_ID), dst, dat,
			redun_of(ASZ'(SRC0_ID), dst, dat) ^ RSZ'(1 + random_bits(3)));
		// Sticky afterwards
		send_good(0);
		send_good(1);
		// Every error case has lit its LED and none has cleared
		if (dbg_leds !== 4'hf) begin
			report_mismatch("dbg_leds", DSZ'(dbg_leds), DSZ'(4'hf));
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: flist.f
ns_msg_pkg.sv
ns_chnl_pkg.sv
calc_redun.sv
chnl_debouncer.sv
msg_source.sv
msg_checker.sv
io_2to1.sv
msg_merge_2to1.sv
ns_loop_top.sv
io_2to1_sva.sv
tb_ns_loop_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_ns_loop_top
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
